/* hdl/cpu_bus_pkg.sv */
package cpu_bus_pkg;

  // word address splits into target select and address inside the target
  localparam int BUS_SEL_W = 2;
  localparam int BUS_ADDR_W = 14;
  localparam int BUS_DATA_W = 16;

  // full cpu word address as seen on the pins
  localparam int BUS_WORD_ADDR_W = BUS_SEL_W + BUS_ADDR_W;

  // target codes carried in the top two address bits
  typedef enum logic [BUS_SEL_W-1:0] {
    BUS_SEL_CONTROLLER = 2'd0,
    BUS_SEL_MOD        = 2'd1,
    BUS_SEL_NORMAL     = 2'd2,
    // stm target exists on the bus but has no receiver here
    BUS_SEL_STM        = 2'd3
  } bus_select_e;

  // one decoded cpu write, as handed to every receiver
  typedef struct packed {
    bus_select_e           select;
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] data;
  } bus_wr_t;

endpackage

/* hdl/ctl_pkg.sv */
package ctl_pkg;

  // controller register map, word addresses inside the controller target
  localparam logic [13:0] ADDR_CTL_FLAG = 14'd0;
  localparam logic [13:0] ADDR_MOD_MEM_WR_PAGE = 14'd1;
  localparam logic [13:0] ADDR_MOD_MEM_RD_PAGE = 14'd2;
  localparam logic [13:0] ADDR_MOD_CYCLE = 14'd3;
  // divider is 32 bits, written as two halves
  localparam logic [13:0] ADDR_MOD_FREQ_DIV_0 = 14'd4;
  localparam logic [13:0] ADDR_MOD_FREQ_DIV_1 = 14'd5;

  // bit positions inside the flag register
  localparam int CTL_FLAG_FORCE_FAN_BIT = 0;
  localparam int CTL_FLAG_SYNC_BIT = 1;

  // controller contents as seen by the design side
  typedef struct packed {
    logic        force_fan;
    logic        sync;
    // page selects for the modulation memory
    logic        mod_wr_page;
    logic        mod_rd_page;
    logic [15:0] mod_cycle;
    logic [31:0] mod_freq_div;
  } ctl_regs_t;

  // two packed modulation samples per bus word
  typedef struct packed {
    // odd sample, upper byte of the word
    logic [7:0] hi;
    // even sample, lower byte of the word
    logic [7:0] lo;
  } mod_pair_t;

  // per-transducer drive word in normal memory
  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } drive_t;

endpackage

/* hdl/bram_sdp.sv */
`timescale 1ns/1ps

module bram_sdp #(
  parameter type word_t = logic [15:0],
  parameter int DEPTH = 256
) (
  input  logic                     CPU_CKIO,
  // write side, driven from the cpu bus
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  word_t                    wdata,
  // read side, design-facing
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output word_t                    rdata
);

  // storage array, inferred as block ram
  word_t mem [DEPTH];

  // write port
  always_ff @(posedge CPU_CKIO) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, data one cycle after raddr
  always_ff @(posedge CPU_CKIO) begin
    rdata <= mem[raddr];
  end

  // callers pass the low bus address bits straight in
  // so an out-of-range write must be caught here
  assert property (@(posedge CPU_CKIO) we |-> (int'(waddr) < DEPTH))
    else $error("bram_sdp: write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

/* hdl/cpu_bus_frontend.sv */
`timescale 1ns/1ps

module cpu_bus_frontend
  import cpu_bus_pkg::*;
(
  input  logic                       CPU_CKIO,
  input  logic                       rst_n,
  // raw cpu sram-style bus
  input  logic [BUS_WORD_ADDR_W-1:0] cpu_addr,
  input  logic [BUS_DATA_W-1:0]      cpu_data,
  input  logic                       cpu_cs1_n,
  input  logic                       cpu_we0_n,
  // one decoded write per strobe
  output logic                       wr_valid,
  output bus_wr_t                    wr
);

  // registered bus pins
  logic [BUS_WORD_ADDR_W-1:0] addr_q;
  logic [BUS_DATA_W-1:0]      data_q;
  logic                       cs_n_q;
  logic                       we_n_q;

  // strobe active and its previous value
  logic wr_active;
  logic wr_active_q;
  logic wr_start;

  // strobes idle high out of reset
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cs_n_q <= 1'b1;
      we_n_q <= 1'b1;
      wr_active_q <= 1'b0;
    end else begin
      cs_n_q <= cpu_cs1_n;
      we_n_q <= cpu_we0_n;
      wr_active_q <= wr_active;
    end
  end

  // address and data sampled alongside the strobes
  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data;
  end

  // write enable low while selected
  assign wr_active = ~cs_n_q & ~we_n_q;
  // first cycle of the strobe only, a long strobe stays one write
  assign wr_start = wr_active & ~wr_active_q;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= wr_start;
    end
  end

  // decode select and in-target address
  always_ff @(posedge CPU_CKIO) begin
    if (wr_start) begin
      wr.select <= bus_select_e'(addr_q[BUS_WORD_ADDR_W-1 -: BUS_SEL_W]);
      wr.addr <= addr_q[BUS_ADDR_W-1:0];
      wr.data <= data_q;
    end
  end

  // receivers count on a single-cycle pulse per cpu write
  assert property (@(posedge CPU_CKIO) disable iff (!rst_n) wr_valid |=> !wr_valid)
    else $error("cpu_bus_frontend: wr_valid held for more than one cycle");

endmodule

/* hdl/controller_regs.sv */
`timescale 1ns/1ps

module controller_regs
  import cpu_bus_pkg::*, ctl_pkg::*;
(
  input  logic      CPU_CKIO,
  input  logic      rst_n,
  // decoded write from the bus front end
  input  logic      wr_valid,
  input  bus_wr_t   wr,
  // register contents for the design side
  output ctl_regs_t regs
);

  // write strobe for this target only
  logic ctl_we;

  assign ctl_we = wr_valid && (wr.select == BUS_SEL_CONTROLLER);

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      regs <= '0;
    end else if (ctl_we) begin
      case (wr.addr)
        // flag word, only the defined bits are kept
        ADDR_CTL_FLAG: begin
          regs.force_fan <= wr.data[CTL_FLAG_FORCE_FAN_BIT];
          regs.sync <= wr.data[CTL_FLAG_SYNC_BIT];
        end
        // page selects take bit 0
        ADDR_MOD_MEM_WR_PAGE: begin
          regs.mod_wr_page <= wr.data[0];
        end
        ADDR_MOD_MEM_RD_PAGE: begin
          regs.mod_rd_page <= wr.data[0];
        end
        // full 16-bit cycle count
        ADDR_MOD_CYCLE: begin
          regs.mod_cycle <= wr.data;
        end
        // divider low half
        ADDR_MOD_FREQ_DIV_0: begin
          regs.mod_freq_div[15:0] <= wr.data;
        end
        // divider high half
        ADDR_MOD_FREQ_DIV_1: begin
          regs.mod_freq_div[31:16] <= wr.data;
        end
        // unmapped addresses are ignored
        default: begin
        end
      endcase
    end
  end

endmodule

/* hdl/mod_memory.sv */
`timescale 1ns/1ps

module mod_memory
  import cpu_bus_pkg::*, ctl_pkg::*;
#(
  parameter int MOD_WORDS = 256
) (
  input  logic                       CPU_CKIO,
  // decoded write from the bus front end
  input  logic                       wr_valid,
  input  bus_wr_t                    wr,
  // page selects from the register bank
  input  logic                       wr_page,
  input  logic                       rd_page,
  // sample index, two samples per word
  input  logic [$clog2(MOD_WORDS):0] mod_idx,
  output logic [7:0]                 mod_sample
);

  // word address width inside one page
  localparam int WORD_AW = $clog2(MOD_WORDS);
  // both pages in one ram, page bit on top
  localparam int RAM_DEPTH = 2 * MOD_WORDS;

  logic               ram_we;
  logic [WORD_AW:0]   ram_waddr;
  logic [WORD_AW:0]   ram_raddr;
  mod_pair_t          ram_wdata;
  mod_pair_t          ram_rdata;
  // odd/even select, aligned with the ram output
  logic               idx_odd_q;

  // mod target, in-range words only
  assign ram_we = wr_valid && (wr.select == BUS_SEL_MOD) && (int'(wr.addr) < MOD_WORDS);
  assign ram_waddr = {wr_page, wr.addr[WORD_AW-1:0]};
  // upper byte is the odd sample
  assign ram_wdata = mod_pair_t'(wr.data);

  // word holding the sample is index / 2
  assign ram_raddr = {rd_page, mod_idx[WORD_AW:1]};

  bram_sdp #(
    .word_t(mod_pair_t),
    .DEPTH (RAM_DEPTH)
  ) u_mod_ram (
    .CPU_CKIO(CPU_CKIO),
    .we      (ram_we),
    .waddr   (ram_waddr),
    .wdata   (ram_wdata),
    .raddr   (ram_raddr),
    .rdata   (ram_rdata)
  );

  // sampled at the same edge as the ram address
  always_ff @(posedge CPU_CKIO) begin
    idx_odd_q <= mod_idx[0];
  end

  // even index gives lo, odd gives hi
  assign mod_sample = idx_odd_q ? ram_rdata.hi : ram_rdata.lo;

endmodule

/* hdl/array_ctl_top.sv */
`timescale 1ns/1ps

module array_ctl_top
  import cpu_bus_pkg::*, ctl_pkg::*;
#(
  parameter int NUM_TRANS = 249,
  parameter int MOD_WORDS = 256
) (
  input  logic                       CPU_CKIO,
  input  logic                       rst_n,
  // cpu bus, write only
  input  logic [BUS_WORD_ADDR_W-1:0] cpu_addr,
  input  logic [BUS_DATA_W-1:0]      cpu_data,
  input  logic                       cpu_cs1_n,
  input  logic                       cpu_we0_n,
  // controller registers
  output ctl_regs_t                  regs,
  // modulation sample readback
  input  logic [$clog2(MOD_WORDS):0] mod_idx,
  output logic [7:0]                 mod_sample,
  // per-transducer drive readback
  input  logic [$clog2(NUM_TRANS)-1:0] trans_idx,
  output drive_t                     drive
);

  // decoded write shared by all receivers
  logic    wr_valid;
  bus_wr_t wr;
  // normal memory write strobe
  logic    normal_we;

  cpu_bus_frontend u_frontend (
    .CPU_CKIO (CPU_CKIO),
    .rst_n    (rst_n),
    .cpu_addr (cpu_addr),
    .cpu_data (cpu_data),
    .cpu_cs1_n(cpu_cs1_n),
    .cpu_we0_n(cpu_we0_n),
    .wr_valid (wr_valid),
    .wr       (wr)
  );

  controller_regs u_regs (
    .CPU_CKIO(CPU_CKIO),
    .rst_n   (rst_n),
    .wr_valid(wr_valid),
    .wr      (wr),
    .regs    (regs)
  );

  // pages come from the register bank
  mod_memory #(
    .MOD_WORDS(MOD_WORDS)
  ) u_mod_mem (
    .CPU_CKIO  (CPU_CKIO),
    .wr_valid  (wr_valid),
    .wr        (wr),
    .wr_page   (regs.mod_wr_page),
    .rd_page   (regs.mod_rd_page),
    .mod_idx   (mod_idx),
    .mod_sample(mod_sample)
  );

  // normal target, range checked inside the ram
  assign normal_we = wr_valid && (wr.select == BUS_SEL_NORMAL);

  // one intensity/phase word per transducer
  bram_sdp #(
    .word_t(drive_t),
    .DEPTH (NUM_TRANS)
  ) u_normal_ram (
    .CPU_CKIO(CPU_CKIO),
    .we      (normal_we),
    .waddr   (wr.addr[$clog2(NUM_TRANS)-1:0]),
    .wdata   (drive_t'(wr.data)),
    .raddr   (trans_idx),
    .rdata   (drive)
  );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic CPU_CKIO,
  output logic rst_n
);

  // free-running cpu clock
  initial begin
    CPU_CKIO = 1'b0;
    forever #(PERIOD_NS / 2) CPU_CKIO = ~CPU_CKIO;
  end

  // reset held over the first rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    rst_n = 1'b1;
  end

endmodule

/* verification/tb_array_ctl.sv */
`timescale 1ns/1ps

module tb_array_ctl
  import cpu_bus_pkg::*, ctl_pkg::*;
();

  localparam int NUM_TRANS = 249;
  localparam int MOD_WORDS = 256;
  localparam int MOD_IDX_W = $clog2(MOD_WORDS) + 1;
  localparam int TRANS_IDX_W = $clog2(NUM_TRANS);
  localparam int RESET_TIMEOUT = 50;
  localparam int NUM_CTL_STEPS = 11;

  // one controller table row with strobe, target, address, data and regs afterwards
  typedef struct packed {
    logic        cs_on;
    bus_select_e sel;
    logic [13:0] addr;
    logic [15:0] data;
    ctl_regs_t   exp;
  } ctl_step_t;

  logic                   CPU_CKIO;
  logic                   rst_n;
  logic [15:0]            cpu_addr;
  logic [15:0]            cpu_data;
  logic                   cpu_cs1_n;
  logic                   cpu_we0_n;
  ctl_regs_t              regs;
  logic [MOD_IDX_W-1:0]   mod_idx;
  logic [7:0]             mod_sample;
  logic [TRANS_IDX_W-1:0] trans_idx;
  drive_t                 drive;

  // reference contents filled as the writes go out
  ctl_regs_t   reg_ref;
  logic [15:0] mod_ref [2*MOD_WORDS];
  logic [15:0] drive_ref [NUM_TRANS];
  logic [31:0] rng_state;
  logic        reset_ok;

  int check_count;
  int error_count;
  int timeout_count;

  // expected regs in field order force_fan, sync, wr_page, rd_page, cycle, divider
  ctl_step_t ctl_table [NUM_CTL_STEPS] = '{
    '{1'b1, BUS_SEL_CONTROLLER, ADDR_CTL_FLAG, 16'h0003,
      '{1'b1, 1'b1, 1'b0, 1'b0, 16'h0000, 32'h0000_0000}},
    '{1'b1, BUS_SEL_CONTROLLER, ADDR_MOD_MEM_WR_PAGE, 16'h0001,
      '{1'b1, 1'b1, 1'b1, 1'b0, 16'h0000, 32'h0000_0000}},
    '{1'b1, BUS_SEL_CONTROLLER, ADDR_MOD_MEM_RD_PAGE, 16'h0001,
      '{1'b1, 1'b1, 1'b1, 1'b1, 16'h0000, 32'h0000_0000}},
    '{1'b1, BUS_SEL_CONTROLLER, ADDR_MOD_CYCLE, 16'h1234,
      '{1'b1, 1'b1, 1'b1, 1'b1, 16'h1234, 32'h0000_0000}},
    '{1'b1, BUS_SEL_CONTROLLER, ADDR_MOD_FREQ_DIV_0, 16'hbeef,
      '{1'b1, 1'b1, 1'b1, 1'b1, 16'h1234, 32'h0000_beef}},
    '{1'b1, BUS_SEL_CONTROLLER, ADDR_MOD_FREQ_DIV_1, 16'hcafe,
      '{1'b1, 1'b1, 1'b1, 1'b1, 16'h1234, 32'hcafe_beef}},
    // unmapped address, zero data would clear any field it aliased onto
    '{1'b1, BUS_SEL_CONTROLLER, 14'h0009, 16'h0000,
      '{1'b1, 1'b1, 1'b1, 1'b1, 16'h1234, 32'hcafe_beef}},
    // chip select held high
    '{1'b0, BUS_SEL_CONTROLLER, ADDR_CTL_FLAG, 16'h0000,
      '{1'b1, 1'b1, 1'b1, 1'b1, 16'h1234, 32'hcafe_beef}},
    '{1'b0, BUS_SEL_CONTROLLER, ADDR_MOD_CYCLE, 16'h0000,
      '{1'b1, 1'b1, 1'b1, 1'b1, 16'h1234, 32'hcafe_beef}},
    '{1'b1, BUS_SEL_CONTROLLER, ADDR_CTL_FLAG, 16'h0002,
      '{1'b0, 1'b1, 1'b1, 1'b1, 16'h1234, 32'hcafe_beef}},
    // only bits 0 and 1 of the flag word count
    '{1'b1, BUS_SEL_CONTROLLER, ADDR_CTL_FLAG, 16'hfffd,
      '{1'b1, 1'b0, 1'b1, 1'b1, 16'h1234, 32'hcafe_beef}}
  };

  tb_clock_gen #(
    .PERIOD_NS   (20),
    .RESET_CYCLES(5)
  ) u_clock_gen (
    .CPU_CKIO(CPU_CKIO),
    .rst_n   (rst_n)
  );

  array_ctl_top #(
    .NUM_TRANS(NUM_TRANS),
    .MOD_WORDS(MOD_WORDS)
  ) uut (
    .CPU_CKIO  (CPU_CKIO),
    .rst_n     (rst_n),
    .cpu_addr  (cpu_addr),
    .cpu_data  (cpu_data),
    .cpu_cs1_n (cpu_cs1_n),
    .cpu_we0_n (cpu_we0_n),
    .regs      (regs),
    .mod_idx   (mod_idx),
    .mod_sample(mod_sample),
    .trans_idx (trans_idx),
    .drive     (drive)
  );

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // page bit and word index both shape the sample pair
  function automatic logic [15:0] mod_pattern(input int page, input int word);
    logic [7:0] base;
    logic       pg;
    base = 8'(word);
    pg = page[0];
    return {base ^ 8'h5a ^ {8{pg}}, base + 8'h31 + {pg, 7'h00}};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[ERROR] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_regs(input ctl_regs_t exp);
    check_value("regs.force_fan", 32'(regs.force_fan), 32'(exp.force_fan));
    check_value("regs.sync", 32'(regs.sync), 32'(exp.sync));
    check_value("regs.mod_wr_page", 32'(regs.mod_wr_page), 32'(exp.mod_wr_page));
    check_value("regs.mod_rd_page", 32'(regs.mod_rd_page), 32'(exp.mod_rd_page));
    check_value("regs.mod_cycle", 32'(regs.mod_cycle), 32'(exp.mod_cycle));
    check_value("regs.mod_freq_div", regs.mod_freq_div, exp.mod_freq_div);
  endtask

  // cs low with address and data, one cycle of we low, then we high for 2 cycles
  task automatic bus_write(input logic cs_on, input bus_select_e sel,
                           input logic [13:0] addr, input logic [15:0] data);
    @(negedge CPU_CKIO);
    cpu_cs1_n = ~cs_on;
    cpu_addr = {sel, addr};
    cpu_data = data;
    @(negedge CPU_CKIO);
    cpu_we0_n = 1'b0;
    @(negedge CPU_CKIO);
    cpu_we0_n = 1'b1;
    repeat (2) @(negedge CPU_CKIO);
    cpu_cs1_n = 1'b1;
  endtask

  task automatic wait_reset_release(output logic ok);
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(negedge CPU_CKIO);
      cycles++;
    end
    ok = (rst_n === 1'b1);
    if (!ok) begin
      $display("timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
    end
  endtask

  task automatic set_ctl(input logic [13:0] addr, input logic [15:0] data);
    bus_write(1'b1, BUS_SEL_CONTROLLER, addr, data);
  endtask

  task automatic fill_mod_page(input int page);
    logic [15:0] data;
    set_ctl(ADDR_MOD_MEM_WR_PAGE, 16'(page));
    reg_ref.mod_wr_page = page[0];
    for (int w = 0; w < MOD_WORDS; w++) begin
      data = mod_pattern(page, w);
      mod_ref[page * MOD_WORDS + w] = data;
      bus_write(1'b1, BUS_SEL_MOD, 14'(w), data);
    end
  endtask

  // even index gives the low byte, odd the high byte
  task automatic read_mod_page(input int page);
    logic [15:0] word;
    logic [7:0]  exp;
    set_ctl(ADDR_MOD_MEM_RD_PAGE, 16'(page));
    reg_ref.mod_rd_page = page[0];
    for (int idx = 0; idx < 2 * MOD_WORDS; idx++) begin
      word = mod_ref[page * MOD_WORDS + idx / 2];
      exp = (idx % 2 == 1) ? word[15:8] : word[7:0];
      @(negedge CPU_CKIO);
      mod_idx = MOD_IDX_W'(idx);
      @(negedge CPU_CKIO);
      check_value($sformatf("mod_sample[page %0d idx %0d]", page, idx),
                  32'(mod_sample), 32'(exp));
    end
  endtask

  task automatic fill_normal();
    for (int t = 0; t < NUM_TRANS; t++) begin
      rng_state = xorshift32(rng_state);
      drive_ref[t] = rng_state[15:0];
      bus_write(1'b1, BUS_SEL_NORMAL, 14'(t), rng_state[15:0]);
    end
  endtask

  // intensity in the upper byte, phase in the lower
  task automatic read_normal();
    for (int t = 0; t < NUM_TRANS; t++) begin
      @(negedge CPU_CKIO);
      trans_idx = TRANS_IDX_W'(t);
      @(negedge CPU_CKIO);
      check_value($sformatf("drive.intensity[%0d]", t), 32'(drive.intensity),
                  32'(drive_ref[t][15:8]));
      check_value($sformatf("drive.phase[%0d]", t), 32'(drive.phase),
                  32'(drive_ref[t][7:0]));
    end
  endtask

  initial begin
    cpu_addr = '0;
    cpu_data = '0;
    cpu_cs1_n = 1'b1;
    cpu_we0_n = 1'b1;
    mod_idx = '0;
    trans_idx = '0;
    reg_ref = '0;
    rng_state = 32'd72497;
    check_count = 0;
    error_count = 0;
    timeout_count = 0;

    wait_reset_release(reset_ok);
    if (!reset_ok) begin
      timeout_count++;
    end else begin
      // everything cleared by reset
      check_regs('0);

      // controller table
      for (int i = 0; i < NUM_CTL_STEPS; i++) begin
        bus_write(ctl_table[i].cs_on, ctl_table[i].sel, ctl_table[i].addr,
                  ctl_table[i].data);
        check_regs(ctl_table[i].exp);
      end
      reg_ref = ctl_table[NUM_CTL_STEPS-1].exp;

      // both modulation pages, written then read back
      fill_mod_page(0);
      fill_mod_page(1);
      read_mod_page(0);
      read_mod_page(1);

      // normal memory
      fill_normal();
      read_normal();

      // out-of-range mod words land nowhere
      // wr page still 1 from the page 1 fill
      bus_write(1'b1, BUS_SEL_MOD, 14'(MOD_WORDS), 16'hdead);
      bus_write(1'b1, BUS_SEL_MOD, 14'h3fff, 16'hbeef);
      // stm writes have no receiver
      bus_write(1'b1, BUS_SEL_STM, ADDR_CTL_FLAG, 16'h0000);
      bus_write(1'b1, BUS_SEL_STM, ADDR_MOD_CYCLE, 16'h5555);
      bus_write(1'b1, BUS_SEL_STM, 14'h0001, 16'ha5a5);
      check_regs(reg_ref);
      read_mod_page(0);
      read_mod_page(1);
      read_normal();
      check_regs(reg_ref);
    end

    $display("checks: %0d  errors: %0d  timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* src.f */
hdl/cpu_bus_pkg.sv
hdl/ctl_pkg.sv
hdl/bram_sdp.sv
hdl/cpu_bus_frontend.sv
hdl/controller_regs.sv
hdl/mod_memory.sv
hdl/array_ctl_top.sv
verification/tb_clock_gen.sv
verification/tb_array_ctl.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_array_ctl
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the run prints the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
